// ==== rtl/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// CSR numbers
`define CSR_CRMD                14'h000
`define CSR_PRMD                14'h001
`define CSR_ECFG                14'h004
`define CSR_ESTAT               14'h005
`define CSR_ERA                 14'h006
`define CSR_EENTRY              14'h00c
`define CSR_SAVE0               14'h030
`define CSR_SAVE1               14'h031
`define CSR_SAVE2               14'h032
`define CSR_SAVE3               14'h033
`define CSR_TCFG                14'h041
`define CSR_TVAL                14'h042
`define CSR_TICLR               14'h044

// DA set, PLV 0
`define CSR_CRMD_RESET          32'h0000_0008

// Writable fields
`define CSR_CRMD_WMASK          32'h0000_01ff
`define CSR_PRMD_WMASK          32'h0000_0007
`define CSR_ECFG_WMASK          32'h0000_1bff
`define CSR_EENTRY_WMASK        32'hffff_ffc0

// ESTAT layout
`define CSR_ESTAT_ECODE_LSB     16
`define CSR_ESTAT_TI_BIT        11

// Timer config bits
`define CSR_TCFG_EN_BIT         0
`define CSR_TCFG_PERIODIC_BIT   1
`define CSR_TCFG_INIT_SHIFT     2

`define CSR_TVAL_RESET          32'hffff_ffff

`endif

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    // One register value
    typedef logic [31:0] csr_word_t;

    // CSR number as seen by the host
    typedef logic [13:0] csr_addr_t;

    // Exception code, lands in ESTAT[21:16]
    typedef logic [5:0] csr_ecode_t;

    // Privilege level, 0 is most privileged
    typedef logic [1:0] csr_plv_t;

    // Host access kind
    typedef enum logic {
        CSR_OP_READ  = 1'b0,
        CSR_OP_WRITE = 1'b1
    } csr_op_t;

endpackage

// ==== rtl/csr_host_port.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_host_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  csr_pkg::csr_op_t   op_i,
    input  csr_pkg::csr_addr_t addr_i,
    input  csr_pkg::csr_word_t wdata_i,
    input  csr_pkg::csr_word_t rd_data_i,
    output logic               ack_o,
    output csr_pkg::csr_word_t rdata_o,
    output logic               wr_stb_o,
    output csr_pkg::csr_addr_t wr_addr_o,
    output csr_pkg::csr_word_t wr_data_o,
    output csr_pkg::csr_addr_t rd_addr_o
);
    import csr_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_ACKED
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      start;
    csr_word_t rdata_q;

    // New request seen while ack is low
    assign start = req_i && (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    state_d = ST_ACKED;
                end
            end
            ST_ACKED: begin
                if (!req_i) begin
                    state_d = ST_IDLE;   // Return to zero phase
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold the last value seen while the request was up
    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= rd_data_i;
        end
    end

    assign ack_o     = (state_q == ST_ACKED);
    assign rdata_o   = (ack_o && req_i) ? rd_data_i : rdata_q;

    // Write lands at the edge that starts the handshake
    assign wr_stb_o  = start && (op_i == CSR_OP_WRITE);
    assign wr_addr_o = addr_i;
    assign wr_data_o = wdata_i;
    assign rd_addr_o = addr_i;

endmodule

// ==== rtl/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_stb_i,
    input  csr_pkg::csr_addr_t wr_addr_i,
    input  csr_pkg::csr_word_t wr_data_i,
    output csr_pkg::csr_word_t tcfg_o,
    output csr_pkg::csr_word_t tval_o,
    output csr_pkg::csr_word_t ticlr_o,
    output logic               timer_irq_o
);
    import csr_pkg::*;

    csr_word_t tcfg_q;
    csr_word_t tval_q;
    csr_word_t wr_init;
    csr_word_t reload_val;
    logic      armed_q;
    logic      irq_q;
    logic      clr_q;
    logic      tcfg_wr;
    logic      clr_wr;
    logic      counting;
    logic      expire;

    assign tcfg_wr    = wr_stb_i && (wr_addr_i == `CSR_TCFG);
    assign clr_wr     = wr_stb_i && (wr_addr_i == `CSR_TICLR) && wr_data_i[0];

    // Initial value is TCFG with the low bits cleared
    assign wr_init    = (wr_data_i >> `CSR_TCFG_INIT_SHIFT) << `CSR_TCFG_INIT_SHIFT;
    assign reload_val = (tcfg_q >> `CSR_TCFG_INIT_SHIFT) << `CSR_TCFG_INIT_SHIFT;

    assign counting   = tcfg_q[`CSR_TCFG_EN_BIT] && armed_q;
    assign expire     = counting && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q  <= '0;
            tval_q  <= `CSR_TVAL_RESET;
            armed_q <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_q  <= wr_data_i;
            tval_q  <= wr_init;
            armed_q <= wr_data_i[`CSR_TCFG_EN_BIT];
        end else if (expire) begin
            if (tcfg_q[`CSR_TCFG_PERIODIC_BIT]) begin
                tval_q <= reload_val;
            end else begin
                armed_q <= 1'b0;   // One-shot parks at zero
            end
        end else if (counting) begin
            tval_q <= tval_q - 32'd1;
        end
    end

    // Sticky until software clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= 1'b0;
            clr_q <= 1'b0;
        end else begin
            clr_q <= clr_wr;
            if (expire) begin
                irq_q <= 1'b1;
            end else if (clr_wr) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    assign ticlr_o     = {31'b0, clr_q};
    assign timer_irq_o = irq_q;

endmodule

// ==== rtl/csr_exc_regs.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_exc_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_stb_i,
    input  csr_pkg::csr_addr_t  wr_addr_i,
    input  csr_pkg::csr_word_t  wr_data_i,
    input  csr_pkg::csr_addr_t  rd_addr_i,
    output csr_pkg::csr_word_t  rd_data_o,
    input  csr_pkg::csr_word_t  tcfg_i,
    input  csr_pkg::csr_word_t  tval_i,
    input  csr_pkg::csr_word_t  ticlr_i,
    input  logic                timer_irq_i,
    input  logic                exc_i,
    input  csr_pkg::csr_ecode_t exc_ecode_i,
    input  csr_pkg::csr_word_t  exc_pc_i,
    input  logic                ertn_i,
    input  logic [7:0]          hwi_i,
    input  logic                ipi_i,
    output csr_pkg::csr_plv_t   crmd_plv_o,
    output logic                crmd_ie_o,
    output csr_pkg::csr_word_t  era_o,
    output csr_pkg::csr_word_t  eentry_o,
    output logic                int_pending_o
);
    import csr_pkg::*;

    csr_word_t  crmd_q;
    csr_word_t  prmd_q;
    csr_word_t  ecfg_q;
    csr_word_t  era_q;
    csr_word_t  eentry_q;
    csr_word_t  save_q [4];
    csr_ecode_t ecode_q;
    logic [1:0] swi_q;
    logic [7:0] hwi_q;
    logic       ipi_q;
    csr_word_t  estat;
    logic       save_hit;

    // Masked merge of a host write into a register
    function automatic csr_word_t merge(csr_word_t old, csr_word_t wdata, csr_word_t mask);
        merge = (old & ~mask) | (wdata & mask);
    endfunction

    assign save_hit = (wr_addr_i >= `CSR_SAVE0) && (wr_addr_i <= `CSR_SAVE3);

    // Exception beats ertn, both beat the host on PLV and IE
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= `CSR_CRMD_RESET;
        end else begin
            if (wr_stb_i && wr_addr_i == `CSR_CRMD) begin
                crmd_q <= merge(crmd_q, wr_data_i, `CSR_CRMD_WMASK);
            end
            if (exc_i) begin
                crmd_q[2:0] <= 3'b000;
            end else if (ertn_i) begin
                crmd_q[2:0] <= prmd_q[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
            ecfg_q <= '0;
        end else begin
            if (exc_i) begin
                prmd_q[2:0] <= crmd_q[2:0];   // Save PLV and IE
            end else if (wr_stb_i && wr_addr_i == `CSR_PRMD) begin
                prmd_q <= merge(prmd_q, wr_data_i, `CSR_PRMD_WMASK);
            end
            if (wr_stb_i && wr_addr_i == `CSR_ECFG) begin
                ecfg_q <= merge(ecfg_q, wr_data_i, `CSR_ECFG_WMASK);
            end
        end
    end

    // ESTAT status fields, interrupt lines sampled every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ecode_q <= '0;
            swi_q   <= '0;
            hwi_q   <= '0;
            ipi_q   <= 1'b0;
        end else begin
            hwi_q <= hwi_i;
            ipi_q <= ipi_i;
            if (exc_i) begin
                ecode_q <= exc_ecode_i;
            end
            if (wr_stb_i && wr_addr_i == `CSR_ESTAT) begin
                swi_q <= wr_data_i[1:0];   // Only the SW interrupt bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_i) begin
            era_q <= exc_pc_i;
        end else if (wr_stb_i && wr_addr_i == `CSR_ERA) begin
            era_q <= wr_data_i;
        end
        if (wr_stb_i && wr_addr_i == `CSR_EENTRY) begin
            eentry_q <= merge(eentry_q, wr_data_i, `CSR_EENTRY_WMASK);
        end
        if (wr_stb_i && save_hit) begin
            save_q[wr_addr_i[1:0]] <= wr_data_i;
        end
    end

    always_comb begin
        estat                                 = '0;
        estat[1:0]                            = swi_q;
        estat[9:2]                            = hwi_q;
        estat[`CSR_ESTAT_TI_BIT]              = timer_irq_i;
        estat[12]                             = ipi_q;
        estat[`CSR_ESTAT_ECODE_LSB +: 6]      = ecode_q;
    end

    always_comb begin
        case (rd_addr_i)
            `CSR_CRMD:   rd_data_o = crmd_q;
            `CSR_PRMD:   rd_data_o = prmd_q;
            `CSR_ECFG:   rd_data_o = ecfg_q;
            `CSR_ESTAT:  rd_data_o = estat;
            `CSR_ERA:    rd_data_o = era_q;
            `CSR_EENTRY: rd_data_o = eentry_q;
            `CSR_SAVE0:  rd_data_o = save_q[0];
            `CSR_SAVE1:  rd_data_o = save_q[1];
            `CSR_SAVE2:  rd_data_o = save_q[2];
            `CSR_SAVE3:  rd_data_o = save_q[3];
            `CSR_TCFG:   rd_data_o = tcfg_i;
            `CSR_TVAL:   rd_data_o = tval_i;
            `CSR_TICLR:  rd_data_o = ticlr_i;
            default:     rd_data_o = '0;
        endcase
    end

    assign crmd_plv_o    = crmd_q[1:0];
    assign crmd_ie_o     = crmd_q[2];
    assign era_o         = era_q;
    assign eentry_o      = eentry_q;
    assign int_pending_o = crmd_q[2] && (|(ecfg_q[12:0] & estat[12:0]));

endmodule

// ==== rtl/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  csr_pkg::csr_op_t    op_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::csr_word_t  wdata_i,
    output logic                ack_o,
    output csr_pkg::csr_word_t  rdata_o,
    input  logic                exc_i,
    input  csr_pkg::csr_ecode_t exc_ecode_i,
    input  csr_pkg::csr_word_t  exc_pc_i,
    input  logic                ertn_i,
    input  logic [7:0]          hwi_i,
    input  logic                ipi_i,
    output csr_pkg::csr_plv_t   crmd_plv_o,
    output logic                crmd_ie_o,
    output csr_pkg::csr_word_t  era_o,
    output csr_pkg::csr_word_t  eentry_o,
    output logic                int_pending_o
);
    import csr_pkg::*;

    logic      wr_stb;
    csr_addr_t wr_addr;
    csr_word_t wr_data;
    csr_addr_t rd_addr;
    csr_word_t rd_data;
    csr_word_t tcfg;
    csr_word_t tval;
    csr_word_t ticlr;
    logic      timer_irq;

    csr_host_port u_host_port (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .op_i      (op_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .rd_data_i (rd_data),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .wr_stb_o  (wr_stb),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .rd_addr_o (rd_addr)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr_stb_i    (wr_stb),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .ticlr_o     (ticlr),
        .timer_irq_o (timer_irq)
    );

    csr_exc_regs u_exc_regs (
        .clk           (clk),
        .rst           (rst),
        .wr_stb_i      (wr_stb),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (rd_data),
        .tcfg_i        (tcfg),
        .tval_i        (tval),
        .ticlr_i       (ticlr),
        .timer_irq_i   (timer_irq),
        .exc_i         (exc_i),
        .exc_ecode_i   (exc_ecode_i),
        .exc_pc_i      (exc_pc_i),
        .ertn_i        (ertn_i),
        .hwi_i         (hwi_i),
        .ipi_i         (ipi_i),
        .crmd_plv_o    (crmd_plv_o),
        .crmd_ie_o     (crmd_ie_o),
        .era_o         (era_o),
        .eentry_o      (eentry_o),
        .int_pending_o (int_pending_o)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    localparam real HALF_PERIOD  = 2.0;   // 4 ns period
    localparam int  RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== tb/csr_assertions.sv ====
`timescale 1ns/1ps

module csr_assertions (
    input logic                clk,
    input logic                rst,
    input logic                req_i,
    input csr_pkg::csr_op_t    op_i,
    input csr_pkg::csr_addr_t  addr_i,
    input csr_pkg::csr_word_t  wdata_i,
    input logic                ack_i,
    input logic                exc_i,
    input csr_pkg::csr_plv_t   crmd_plv_i
);
    int unsigned fail_cnt = 0;

    // Four-phase return to zero
    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            fail_cnt++;
            $error("ack_o fell while req_i was still high");
        end

    req_fields_stable: assert property (@(posedge clk) disable iff (rst)
        (req_i && $past(req_i)) |-> ($stable(op_i) && $stable(addr_i) && $stable(wdata_i)))
        else begin
            fail_cnt++;
            $error("request fields changed while req_i was high");
        end

    exc_drops_plv: assert property (@(posedge clk) disable iff (rst)
        exc_i |=> (crmd_plv_i == '0))
        else begin
            fail_cnt++;
            $error("crmd_plv_o not zero the cycle after exc_i");
        end

endmodule

bind csr_top csr_assertions u_csr_assertions (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req_i),
    .op_i       (op_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .ack_i      (ack_o),
    .exc_i      (exc_i),
    .crmd_plv_i (crmd_plv_o)
);

// ==== tb/csr_tb.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb;
    import csr_pkg::*;

    localparam string DATA_FILE = "tb/csr_testdata.txt";
    localparam int    ACK_WAIT  = 8;

    logic       clk;
    logic       rst;
    logic       req;
    csr_op_t    op;
    csr_addr_t  addr;
    csr_word_t  wdata;
    logic       ack;
    csr_word_t  rdata;
    logic       exc;
    csr_ecode_t exc_ecode;
    csr_word_t  exc_pc;
    logic       ertn;
    logic [7:0] hwi;
    logic       ipi;
    csr_plv_t   crmd_plv;
    logic       crmd_ie;
    csr_word_t  era;
    csr_word_t  eentry;
    logic       int_pending;

    string      op_q[$];
    csr_word_t  a_q[$];
    csr_word_t  b_q[$];
    csr_word_t  exp_q[$];

    int seed          = 32'hb939;
    int cycle_cnt     = 0;
    int timeout_limit = 0;
    int access_cycle  = 0;
    int tcfg_cycle    = 0;
    int value_errors  = 0;
    int other_errors  = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    csr_top u_csr_top (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .op_i          (op),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .ack_o         (ack),
        .rdata_o       (rdata),
        .exc_i         (exc),
        .exc_ecode_i   (exc_ecode),
        .exc_pc_i      (exc_pc),
        .ertn_i        (ertn),
        .hwi_i         (hwi),
        .ipi_i         (ipi),
        .crmd_plv_o    (crmd_plv),
        .crmd_ie_o     (crmd_ie),
        .era_o         (era),
        .eentry_o      (eentry),
        .int_pending_o (int_pending)
    );

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word_max(input string name, input csr_word_t got, input csr_word_t max);
        if (got > max || $isunknown(got)) begin
            value_errors++;
            $display("FAIL %s: got %h, expected at most %h", name, got, max);
        end
    endtask

    task automatic check_plv(input string name, input csr_plv_t got, input csr_plv_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_testdata();
        int        fd;
        int        n;
        string     line;
        string     kind;
        csr_word_t a;
        csr_word_t b;
        csr_word_t e;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: cannot open %s", DATA_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %h %h %h", kind, a, b, e);
                if (n == 4) begin
                    op_q.push_back(kind);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    exp_q.push_back(e);
                end else begin
                    other_errors++;
                    $display("ERROR: malformed line in %s: %s", DATA_FILE, line);
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            other_errors++;
            $display("ERROR: no operations found in %s", DATA_FILE);
        end
    endtask

    // One four-phase handshake, entered and left on a falling edge
    task automatic host_access(input csr_op_t kind, input csr_addr_t a, input csr_word_t d,
                               output csr_word_t rd);
        int waited;

        if (ack !== 1'b0) begin
            other_errors++;
            $display("ERROR: ack still high before a new request to csr %h", a);
        end
        req   = 1'b1;
        op    = kind;
        addr  = a;
        wdata = d;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b1) begin
            other_errors++;
            $display("ERROR: no ack for the access to csr %h", a);
        end
        rd = rdata;
        access_cycle = cycle_cnt;
        req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b0 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b0) begin
            other_errors++;
            $display("ERROR: ack stayed high after the request to csr %h dropped", a);
        end
    endtask

    task automatic pulse_exc(input csr_ecode_t code, input csr_word_t pc, input csr_word_t exp_era);
        exc       = 1'b1;
        exc_ecode = code;
        exc_pc    = pc;
        @(negedge clk);
        exc = 1'b0;
        check_plv("crmd_plv_o", crmd_plv, 2'd0);
        check_bit("crmd_ie_o", crmd_ie, 1'b0);
        check_word("era_o", era, exp_era);
    endtask

    task automatic pulse_ertn(input logic [2:0] saved);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        check_plv("crmd_plv_o", crmd_plv, saved[1:0]);
        check_bit("crmd_ie_o", crmd_ie, saved[2]);
    endtask

    task automatic drive_hwi(input logic [7:0] lines, input logic exp_pending);
        hwi = lines;
        @(negedge clk);   // Sampled into ESTAT one cycle later
        check_bit("int_pending_o", int_pending, exp_pending);
    endtask

    // Back-to-back ESTAT reads until TI shows up
    task automatic wait_timer_irq(input csr_word_t init, input logic exp_ti);
        csr_word_t v;
        int        limit;
        int        elapsed;

        limit   = int'(init) + 3;
        elapsed = 0;
        v       = '0;
        while (v[`CSR_ESTAT_TI_BIT] !== 1'b1 && elapsed <= limit) begin
            host_access(CSR_OP_READ, `CSR_ESTAT, '0, v);
            elapsed = access_cycle - tcfg_cycle;
        end
        check_bit("ESTAT[11]", v[`CSR_ESTAT_TI_BIT], exp_ti);
        if (v[`CSR_ESTAT_TI_BIT] === 1'b1 && elapsed > limit) begin
            other_errors++;
            $display("ERROR: timer interrupt took %0d cycles, limit is %0d", elapsed, limit);
        end
    endtask

    task automatic run_line(input string kind, input csr_word_t a, input csr_word_t b,
                            input csr_word_t exp);
        csr_word_t rd;
        string     name;

        name = $sformatf("rdata_o (csr %h)", a[13:0]);
        if (kind == "wr") begin
            host_access(CSR_OP_WRITE, a[13:0], b, rd);
            if (a[13:0] == `CSR_TCFG) begin
                tcfg_cycle = access_cycle;   // Timer starts here
            end
            check_word(name, rd, exp);
            if (a[13:0] == `CSR_EENTRY) begin
                check_word("eentry_o", eentry, exp);
            end
        end else if (kind == "rd") begin
            host_access(CSR_OP_READ, a[13:0], '0, rd);
            check_word(name, rd, exp);
            if (a[13:0] == `CSR_EENTRY) begin
                check_word("eentry_o", eentry, exp);
            end
        end else if (kind == "rmax") begin
            host_access(CSR_OP_READ, a[13:0], '0, rd);
            check_word_max(name, rd, exp);
        end else if (kind == "exc") begin
            pulse_exc(a[5:0], b, exp);
        end else if (kind == "ertn") begin
            pulse_ertn(exp[2:0]);
        end else if (kind == "hwi") begin
            drive_hwi(a[7:0], exp[0]);
        end else if (kind == "irq") begin
            wait_timer_irq(b, exp[0]);
        end else begin
            other_errors++;
            $display("ERROR: unknown operation %s in %s", kind, DATA_FILE);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, int'(u_csr_top.u_csr_assertions.fail_cnt));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("ERROR: run did not finish within %0d cycles", timeout_limit);
            print_error_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int gap;
        int max_init;

        req       = 1'b0;
        op        = CSR_OP_READ;
        addr      = '0;
        wdata     = '0;
        exc       = 1'b0;
        exc_ecode = '0;
        exc_pc    = '0;
        ertn      = 1'b0;
        hwi       = '0;
        ipi       = 1'b0;

        load_testdata();
        max_init = 0;
        foreach (op_q[i]) begin
            if (op_q[i] == "irq" && int'(b_q[i]) > max_init) begin
                max_init = int'(b_q[i]);
            end
        end
        timeout_limit = 10 * op_q.size() + max_init + 10;

        @(negedge rst);
        @(negedge clk);
        foreach (op_q[i]) begin
            run_line(op_q[i], a_q[i], b_q[i], exp_q[i]);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
        end

        print_error_counts();
        if (value_errors == 0 && other_errors == 0
                && u_csr_top.u_csr_assertions.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_host_port.sv
rtl/csr_timer.sv
rtl/csr_exc_regs.sv
rtl/csr_top.sv
tb/tb_clock_gen.sv
tb/csr_assertions.sv
tb/csr_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR block testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/csr_testdata.txt ====
# op  addr/ecode/hwi  data  expected (all hex)
# irq: data is the timer initial value; ertn: expected is the saved {IE,PLV}
wr   0030 ffffffff ffffffff
wr   0031 ffffffff ffffffff
wr   0032 12345678 12345678
wr   0033 ffffffff ffffffff
wr   0000 ffffffff 000001ff
wr   0001 ffffffff 00000007
wr   0004 ffffffff 00001bff
wr   000c ffffffff ffffffc0
rd   0033 00000000 ffffffff
rd   0032 00000000 12345678
rd   0000 00000000 000001ff
rd   0004 00000000 00001bff
rd   000c 00000000 ffffffc0
rd   0123 00000000 00000000
wr   0000 00000007 00000007
wr   0001 00000000 00000000
exc  000b 1c000100 1c000100
rd   0001 00000000 00000007
rd   0005 00000000 000b0000
rd   0006 00000000 1c000100
rd   0000 00000000 00000000
ertn 0000 00000000 00000007
hwi  00a5 00000000 00000001
rd   0005 00000000 000b0294
wr   0004 00000003 00000003
hwi  00a5 00000000 00000000
hwi  0000 00000000 00000000
wr   0041 00000011 00000011
irq  0000 00000010 00000001
wr   0044 00000001 00000001
rd   0005 00000000 000b0000
rd   0042 00000000 00000000
wr   0041 00000013 00000013
irq  0000 00000010 00000001
rmax 0042 00000000 00000010
wr   0041 00000000 00000000
wr   0044 00000001 00000001
rd   0005 00000000 000b0000
